// ==== Bender.yml ====
package:
  name: csr_trap_unit

sources:
  - csr_arch_pkg.sv
  - csr_io_pkg.sv
  - csr_regfile.sv
  - event_timer.sv
  - trap_controller.sv
  - csr_trap_unit.sv
  - target: test
    files:
      - tb_csr_trap_unit.sv

// ==== csr_arch_pkg.sv ====
`default_nettype none

package csr_arch_pkg;

	localparam int XLEN = 32;

	// delegation register widths
	localparam int MEDELEG_W = 16;
	localparam int MIDELEG_W = 12;

	typedef enum logic [1:0] {
		MODE_U = 2'b00,
		MODE_S = 2'b01,
		MODE_M = 2'b11	// 2'b10 is reserved
	} mode_t;

	// machine information, read only
	localparam logic [11:0] CSR_MVENDORID = 12'hF11;
	localparam logic [11:0] CSR_MARCHID   = 12'hF12;
	localparam logic [11:0] CSR_MIMPID    = 12'hF13;
	localparam logic [11:0] CSR_MHARTID   = 12'hF14;

	// machine trap setup and handling
	localparam logic [11:0] CSR_MSTATUS   = 12'h300;
	localparam logic [11:0] CSR_MISA      = 12'h301;
	localparam logic [11:0] CSR_MEDELEG   = 12'h302;
	localparam logic [11:0] CSR_MIDELEG   = 12'h303;
	localparam logic [11:0] CSR_MIE       = 12'h304;
	localparam logic [11:0] CSR_MTVEC     = 12'h305;
	localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
	localparam logic [11:0] CSR_MEPC      = 12'h341;
	localparam logic [11:0] CSR_MCAUSE    = 12'h342;
	localparam logic [11:0] CSR_MTVAL     = 12'h343;
	localparam logic [11:0] CSR_MIP       = 12'h344;

	// supervisor
	localparam logic [11:0] CSR_SSTATUS   = 12'h100;
	localparam logic [11:0] CSR_SIE       = 12'h104;
	localparam logic [11:0] CSR_STVEC     = 12'h105;
	localparam logic [11:0] CSR_SSCRATCH  = 12'h140;
	localparam logic [11:0] CSR_SEPC      = 12'h141;
	localparam logic [11:0] CSR_SCAUSE    = 12'h142;
	localparam logic [11:0] CSR_STVAL     = 12'h143;
	localparam logic [11:0] CSR_SIP       = 12'h144;

	// event timer compares, custom space
	localparam logic [11:0] CSR_MNECYCLE  = 12'h7C0;
	localparam logic [11:0] CSR_SNECYCLE  = 12'h5C0;

	// exception codes
	localparam logic [XLEN-2:0] I_ADDR_MISALIGNED = 31'd0;
	localparam logic [XLEN-2:0] I_ILLEGAL         = 31'd2;

	// interrupt codes, used with the interrupt bit set
	localparam logic [XLEN-2:0] IRQ_S_TIMER = 31'd5;
	localparam logic [XLEN-2:0] IRQ_M_TIMER = 31'd7;
	localparam logic [XLEN-2:0] IRQ_S_EXT   = 31'd9;
	localparam logic [XLEN-2:0] IRQ_M_EXT   = 31'd11;

endpackage

`default_nettype wire

// ==== csr_io_pkg.sv ====
`default_nettype none

package csr_io_pkg;

	// software access from the pipeline, one strobe per cycle
	typedef struct packed {
		logic valid;
		logic write;
		logic [11:0] addr;
		logic [csr_arch_pkg::XLEN-1:0] wdata;
	} csr_access_t;

	typedef struct packed {
		logic irq;	// interrupt bit
		logic [csr_arch_pkg::XLEN-2:0] code;
	} cause_t;

	// exception or return request; pc is the current instruction
	typedef struct packed {
		logic valid;
		logic mret;
		logic sret;
		cause_t cause;
		logic [csr_arch_pkg::XLEN-1:0] pc;
	} trap_req_t;

	// regfile state seen by the trap controller
	typedef struct packed {
		csr_arch_pkg::mode_t mode;
		csr_arch_pkg::mode_t mpp;
		logic spp;
		logic mie;	// mstatus.mie
		logic sie;	// mstatus.sie
		logic meie;
		logic mtie;
		logic seie;
		logic stie;
		logic [csr_arch_pkg::MEDELEG_W-1:0] medeleg;
		logic [csr_arch_pkg::MIDELEG_W-1:0] mideleg;
	} trap_state_t;

	typedef struct packed {
		logic valid;
		logic [csr_arch_pkg::XLEN-1:0] pc;
	} redirect_t;

endpackage

`default_nettype wire

// ==== csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
(
	input  logic clk,
	input  logic nrst,
	input  csr_io_pkg::csr_access_t access,
	input  logic take_trap,
	input  csr_io_pkg::trap_req_t trap,
	input  csr_arch_pkg::mode_t target_mode,
	input  logic m_timer,
	input  logic s_timer,
	input  logic m_ext,
	input  logic s_ext,
	output logic [31:0] rdata,
	output logic hit,
	output csr_io_pkg::trap_state_t state,
	output logic [31:0] mtvec,
	output logic [31:0] stvec,
	output logic [31:0] mepc,
	output logic [31:0] sepc
);

	csr_arch_pkg::mode_t cur_mode;
	csr_arch_pkg::mode_t st_mpp;
	logic st_sie, st_mie, st_spie, st_mpie, st_spp, st_sum;
	logic meie, mtie, seie, stie;
	logic [31:2] mtvec_q, stvec_q, mepc_q, sepc_q;	// direct mode, word aligned
	logic [31:0] mscratch, sscratch, mcause, scause, mtval, stval;
	logic [csr_arch_pkg::MEDELEG_W-1:0] medeleg;
	logic [csr_arch_pkg::MIDELEG_W-1:0] mideleg;

	logic [31:0] mstatus_v, sstatus_v, mie_v, sie_v, mip_v, sip_v;
	logic [31:0] tval_next;
	logic sw_we;

	assign mstatus_v = {13'b0, st_sum, 5'b0, st_mpp, 2'b0, st_spp, st_mpie, 1'b0,
		st_spie, 1'b0, st_mie, 1'b0, st_sie, 1'b0};
	assign sstatus_v = {13'b0, st_sum, 9'b0, st_spp, 2'b0, st_spie, 3'b0, st_sie, 1'b0};
	assign mie_v = {20'b0, meie, 1'b0, seie, 1'b0, mtie, 1'b0, stie, 5'b0};
	assign sie_v = {22'b0, seie, 3'b0, stie, 5'b0};
	assign mip_v = {20'b0, m_ext, 1'b0, s_ext, 1'b0, m_timer, 1'b0, s_timer, 5'b0};
	assign sip_v = {22'b0, s_ext, 3'b0, s_timer, 5'b0};

	assign mtvec = {mtvec_q, 2'b00};
	assign stvec = {stvec_q, 2'b00};
	assign mepc  = {mepc_q, 2'b00};
	assign sepc  = {sepc_q, 2'b00};

	// trap entry has priority over software writes
	assign sw_we = access.valid && access.write && !take_trap;

	// tval only carries the faulting pc for a misaligned fetch
	assign tval_next = (!trap.cause.irq && trap.cause.code == csr_arch_pkg::I_ADDR_MISALIGNED)
		? trap.pc : 32'b0;

	always_comb
	begin
		hit = access.valid;
		case (access.addr)
			csr_arch_pkg::CSR_MISA:      rdata = {2'b01, 4'b0, 26'h0140100};	// I, S, U
			csr_arch_pkg::CSR_MVENDORID,
			csr_arch_pkg::CSR_MARCHID,
			csr_arch_pkg::CSR_MIMPID,
			csr_arch_pkg::CSR_MHARTID:   rdata = 32'b0;
			csr_arch_pkg::CSR_MSTATUS:   rdata = mstatus_v;
			csr_arch_pkg::CSR_MEDELEG:   rdata = {16'b0, medeleg};
			csr_arch_pkg::CSR_MIDELEG:   rdata = {20'b0, mideleg};
			csr_arch_pkg::CSR_MIE:       rdata = mie_v;
			csr_arch_pkg::CSR_MTVEC:     rdata = mtvec;
			csr_arch_pkg::CSR_MSCRATCH:  rdata = mscratch;
			csr_arch_pkg::CSR_MEPC:      rdata = mepc;
			csr_arch_pkg::CSR_MCAUSE:    rdata = mcause;
			csr_arch_pkg::CSR_MTVAL:     rdata = mtval;
			csr_arch_pkg::CSR_MIP:       rdata = mip_v;
			csr_arch_pkg::CSR_SSTATUS:   rdata = sstatus_v;
			csr_arch_pkg::CSR_SIE:       rdata = sie_v;
			csr_arch_pkg::CSR_STVEC:     rdata = stvec;
			csr_arch_pkg::CSR_SSCRATCH:  rdata = sscratch;
			csr_arch_pkg::CSR_SEPC:      rdata = sepc;
			csr_arch_pkg::CSR_SCAUSE:    rdata = scause;
			csr_arch_pkg::CSR_STVAL:     rdata = stval;
			csr_arch_pkg::CSR_SIP:       rdata = sip_v;
			default:
			begin
				rdata = 32'b0;
				hit = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			cur_mode <= csr_arch_pkg::MODE_M;
			st_mpp <= csr_arch_pkg::MODE_U;
			st_sie <= 1'b0;
			st_mie <= 1'b0;
			st_spie <= 1'b0;
			st_mpie <= 1'b0;
			st_spp <= 1'b0;
			st_sum <= 1'b0;
			meie <= 1'b0;
			mtie <= 1'b0;
			seie <= 1'b0;
			stie <= 1'b0;
			mtvec_q <= '0;
			stvec_q <= '0;
			mepc_q <= '0;
			sepc_q <= '0;
			mscratch <= '0;
			sscratch <= '0;
			mcause <= '0;
			scause <= '0;
			mtval <= '0;
			stval <= '0;
			medeleg <= '0;
			mideleg <= '0;
		end
		else if (take_trap)
		begin
			cur_mode <= target_mode;
			if (target_mode == csr_arch_pkg::MODE_M)
			begin
				mepc_q <= trap.pc[31:2];
				mcause <= trap.cause;
				mtval <= tval_next;
				st_mpie <= st_mie;
				st_mie <= 1'b0;
				st_mpp <= cur_mode;
			end
			else
			begin
				sepc_q <= trap.pc[31:2];
				scause <= trap.cause;
				stval <= tval_next;
				st_spie <= st_sie;
				st_sie <= 1'b0;
				st_spp <= cur_mode[0];	// U or S only
			end
		end
		else
		begin
			if (sw_we)
			begin
				case (access.addr)
					csr_arch_pkg::CSR_MSTATUS:
					begin
						st_sie <= access.wdata[1];
						st_mie <= access.wdata[3];
						st_spie <= access.wdata[5];
						st_mpie <= access.wdata[7];
						st_spp <= access.wdata[8];
						if (access.wdata[12:11] != 2'b10)	// WARL, reserved value dropped
							st_mpp <= csr_arch_pkg::mode_t'(access.wdata[12:11]);
						st_sum <= access.wdata[18];
					end
					csr_arch_pkg::CSR_SSTATUS:
					begin
						st_sie <= access.wdata[1];
						st_spie <= access.wdata[5];
						st_spp <= access.wdata[8];
						st_sum <= access.wdata[18];
					end
					csr_arch_pkg::CSR_MIE:
					begin
						stie <= access.wdata[5];
						mtie <= access.wdata[7];
						seie <= access.wdata[9];
						meie <= access.wdata[11];
					end
					csr_arch_pkg::CSR_SIE:
					begin
						stie <= access.wdata[5];
						seie <= access.wdata[9];
					end
					csr_arch_pkg::CSR_MEDELEG:  medeleg <= access.wdata[15:0];
					csr_arch_pkg::CSR_MIDELEG:  mideleg <= access.wdata[11:0];
					csr_arch_pkg::CSR_MTVEC:    mtvec_q <= access.wdata[31:2];
					csr_arch_pkg::CSR_STVEC:    stvec_q <= access.wdata[31:2];
					csr_arch_pkg::CSR_MSCRATCH: mscratch <= access.wdata;
					csr_arch_pkg::CSR_SSCRATCH: sscratch <= access.wdata;
					csr_arch_pkg::CSR_MEPC:     mepc_q <= access.wdata[31:2];
					csr_arch_pkg::CSR_SEPC:     sepc_q <= access.wdata[31:2];
					csr_arch_pkg::CSR_MCAUSE:   mcause <= access.wdata;
					csr_arch_pkg::CSR_SCAUSE:   scause <= access.wdata;
					csr_arch_pkg::CSR_MTVAL:    mtval <= access.wdata;
					csr_arch_pkg::CSR_STVAL:    stval <= access.wdata;
					default: ;
				endcase
			end
			// returns pop the status stack, target mode comes from mpp or spp
			if (trap.valid && trap.mret)
			begin
				cur_mode <= target_mode;
				st_mie <= st_mpie;
				st_mpie <= 1'b1;
				st_mpp <= csr_arch_pkg::MODE_U;
			end
			else if (trap.valid && trap.sret)
			begin
				cur_mode <= target_mode;
				st_sie <= st_spie;
				st_spie <= 1'b1;
				st_spp <= 1'b0;
			end
		end
	end

	always_comb
	begin
		state.mode = cur_mode;
		state.mpp = st_mpp;
		state.spp = st_spp;
		state.mie = st_mie;
		state.sie = st_sie;
		state.meie = meie;
		state.mtie = mtie;
		state.seie = seie;
		state.stie = stie;
		state.medeleg = medeleg;
		state.mideleg = mideleg;
	end

	// a trap or return never lands in the reserved mode
	a_mode_legal: assert property (@(posedge clk) disable iff (!nrst)
		(take_trap || trap.valid) |=> cur_mode inside {csr_arch_pkg::MODE_U,
		csr_arch_pkg::MODE_S, csr_arch_pkg::MODE_M})
		else $error("mode entered the reserved encoding");

endmodule

`default_nettype wire

// ==== csr_stim.txt ====
# columns: op addr data pc cause expect, hex. ops: W write, R read and compare, T trap request,
# M mret, S sret, I idle for data cycles (expect 0: no redirect, else one redirect to expect)
# timer compares parked at all ones
W 7c0 ffffffff 00000000 00000000 00000000
W 5c0 ffffffff 00000000 00000000 00000000
R 7c0 00000000 00000000 00000000 ffffffff
R 5c0 00000000 00000000 00000000 ffffffff
# software write and read back
W 340 a5a51234 00000000 00000000 00000000
R 340 00000000 00000000 00000000 a5a51234
W 140 0f0f0f0f 00000000 00000000 00000000
R 140 00000000 00000000 00000000 0f0f0f0f
W 305 00001003 00000000 00000000 00000000
R 305 00000000 00000000 00000000 00001000
W 105 00002002 00000000 00000000 00000000
R 105 00000000 00000000 00000000 00002000
W 304 ffffffff 00000000 00000000 00000000
R 304 00000000 00000000 00000000 00000aa0
R 104 00000000 00000000 00000000 00000220
R 7ff 00000000 00000000 00000000 00000000
R 5c1 00000000 00000000 00000000 00000000
# all enables on with the compares at all ones
W 300 00000008 00000000 00000000 00000000
R 300 00000000 00000000 00000000 00000008
I 000 00000020 00000000 00000000 00000000
W 300 00000000 00000000 00000000 00000000
# exceptions taken in M
T 000 00000000 00000104 00000002 00001000
R 341 00000000 00000000 00000000 00000104
R 342 00000000 00000000 00000000 00000002
R 343 00000000 00000000 00000000 00000000
R 300 00000000 00000000 00000000 00001800
T 000 00000000 00000202 00000000 00001000
R 341 00000000 00000000 00000000 00000200
R 343 00000000 00000000 00000000 00000202
R 300 00000000 00000000 00000000 00001800
# mret into S
W 300 00000880 00000000 00000000 00000000
R 300 00000000 00000000 00000000 00000880
W 341 00000400 00000000 00000000 00000000
M 000 00000000 00000000 00000000 00000400
R 300 00000000 00000000 00000000 00000088
# delegated exception from S
W 302 00000004 00000000 00000000 00000000
R 302 00000000 00000000 00000000 00000004
T 000 00000000 00000500 00000002 00002000
R 141 00000000 00000000 00000000 00000500
R 142 00000000 00000000 00000000 00000002
R 143 00000000 00000000 00000000 00000000
R 100 00000000 00000000 00000000 00000100
R 300 00000000 00000000 00000000 00000188
# sret stays in S, an undelegated trap then shows mpp = S
W 100 00000120 00000000 00000000 00000000
S 000 00000000 00000000 00000000 00000500
R 100 00000000 00000000 00000000 00000022
W 302 00000000 00000000 00000000 00000000
T 000 00000000 00000600 00000002 00001000
R 300 00000000 00000000 00000000 000008a2
R 341 00000000 00000000 00000000 00000600
# mret to S, sret to U, misaligned fetch from U
M 000 00000000 00000000 00000000 00000600
R 300 00000000 00000000 00000000 000000aa
S 000 00000000 00000000 00000000 00000500
T 000 00000000 00000702 00000000 00001000
R 300 00000000 00000000 00000000 000000a2
R 341 00000000 00000000 00000000 00000700
R 343 00000000 00000000 00000000 00000702
# mret to U, then a delegated trap from U
M 000 00000000 00000000 00000000 00000700
W 302 00000004 00000000 00000000 00000000
T 000 00000000 00000900 00000002 00002000
R 141 00000000 00000000 00000000 00000900
R 100 00000000 00000000 00000000 00000020
W 302 00000000 00000000 00000000 00000000
T 000 00000000 00000a00 00000002 00001000
R 300 00000000 00000000 00000000 000008a0
# machine timer interrupt
W 7c0 00000000 00000000 00000000 00000000
W 304 00000080 00000000 00000000 00000000
W 300 00000008 00000000 00000000 00000000
I 000 00000004 00000a40 00000000 00001000
R 342 00000000 00000000 00000000 80000007
R 341 00000000 00000000 00000000 00000a40
R 300 00000000 00000000 00000000 00001880
R 344 00000000 00000000 00000000 00000080

// ==== csr_trap_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_trap_unit
#(
	parameter int COUNT_WIDTH = 32
)
(
	input  logic clk,
	input  logic nrst,
	input  csr_io_pkg::csr_access_t csr_access,
	input  csr_io_pkg::trap_req_t trap_req,
	input  logic m_ext,
	input  logic s_ext,
	output logic [31:0] rdata,
	output csr_io_pkg::redirect_t redirect
);

	csr_io_pkg::trap_state_t state;
	csr_io_pkg::trap_req_t cause_out;	// request with interrupt cause filled in
	csr_arch_pkg::mode_t target_mode;
	logic take_trap;
	logic m_timer, s_timer;
	logic [31:0] reg_rdata, tmr_rdata;
	logic reg_hit, tmr_hit;
	logic [31:0] mtvec, stvec, mepc, sepc;

	csr_regfile csr_regfile_inst
	(
		.clk         (clk),
		.nrst        (nrst),
		.access      (csr_access),
		.take_trap   (take_trap),
		.trap        (cause_out),
		.target_mode (target_mode),
		.m_timer     (m_timer),
		.s_timer     (s_timer),
		.m_ext       (m_ext),
		.s_ext       (s_ext),
		.rdata       (reg_rdata),
		.hit         (reg_hit),
		.state       (state),
		.mtvec       (mtvec),
		.stvec       (stvec),
		.mepc        (mepc),
		.sepc        (sepc)
	);

	event_timer
	#(
		.COUNT_WIDTH (COUNT_WIDTH)
	)
	event_timer_inst
	(
		.clk     (clk),
		.nrst    (nrst),
		.access  (csr_access),
		.rdata   (tmr_rdata),
		.hit     (tmr_hit),
		.m_timer (m_timer),
		.s_timer (s_timer)
	);

	trap_controller trap_controller_inst
	(
		.trap        (trap_req),
		.state       (state),
		.m_timer     (m_timer),
		.s_timer     (s_timer),
		.m_ext       (m_ext),
		.s_ext       (s_ext),
		.reg_rdata   (reg_rdata),
		.reg_hit     (reg_hit),
		.tmr_rdata   (tmr_rdata),
		.tmr_hit     (tmr_hit),
		.mtvec       (mtvec),
		.stvec       (stvec),
		.mepc        (mepc),
		.sepc        (sepc),
		.rdata       (rdata),
		.take_trap   (take_trap),
		.target_mode (target_mode),
		.cause_out   (cause_out),
		.redirect    (redirect)
	);

endmodule

`default_nettype wire

// ==== event_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module event_timer
#(
	parameter int COUNT_WIDTH = 32	// 16 to 32
)
(
	input  logic clk,
	input  logic nrst,
	input  csr_io_pkg::csr_access_t access,
	output logic [31:0] rdata,
	output logic hit,
	output logic m_timer,
	output logic s_timer
);

	logic [COUNT_WIDTH-1:0] count;
	logic [COUNT_WIDTH-1:0] m_cmp;
	logic [COUNT_WIDTH-1:0] s_cmp;
	logic [31:0] m_cmp_ext, s_cmp_ext;
	logic m_sel, s_sel;

	assign m_sel = access.valid && (access.addr == csr_arch_pkg::CSR_MNECYCLE);
	assign s_sel = access.valid && (access.addr == csr_arch_pkg::CSR_SNECYCLE);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			count <= '0;
			m_cmp <= '0;
			s_cmp <= '0;
			m_timer <= 1'b0;
			s_timer <= 1'b0;
		end
		else
		begin
			count <= count + 1'b1;	// free running
			if (m_sel && access.write)
				m_cmp <= access.wdata[COUNT_WIDTH-1:0];
			if (s_sel && access.write)
				s_cmp <= access.wdata[COUNT_WIDTH-1:0];
			m_timer <= (count >= m_cmp);
			s_timer <= (count >= s_cmp);
		end
	end

	always_comb
	begin
		m_cmp_ext = 32'b0;
		s_cmp_ext = 32'b0;
		m_cmp_ext[COUNT_WIDTH-1:0] = m_cmp;	// zero extend for readback
		s_cmp_ext[COUNT_WIDTH-1:0] = s_cmp;
		hit = m_sel || s_sel;
		rdata = m_sel ? m_cmp_ext : (s_sel ? s_cmp_ext : 32'b0);
	end

	// by the time the counter wraps both compares must have been programmed
	a_no_wrap_at_zero: assert property (@(posedge clk) disable iff (!nrst)
		(count == '1) |-> (m_cmp != '0 && s_cmp != '0))
		else $error("counter wrapped with a zero compare");

endmodule

`default_nettype wire

// ==== src.f ====
csr_arch_pkg.sv
csr_io_pkg.sv
csr_regfile.sv
event_timer.sv
trap_controller.sv
csr_trap_unit.sv
tb_csr_trap_unit.sv

// ==== tb_csr_trap_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csr_trap_unit;

	localparam int CLK_PERIOD = 8;
	localparam int COUNT_WIDTH = 32;
	localparam int CYCLES_PER_OP = 40;	// watchdog budget per stim line

	// one parsed line of the stim file
	typedef struct packed {
		logic [7:0] op;
		logic [11:0] addr;
		logic [31:0] data;
		logic [31:0] pc;
		logic [31:0] cause;
		logic [31:0] exp_val;
		logic [15:0] idx;
	} stim_t;

	logic clk;
	logic nrst;
	csr_io_pkg::csr_access_t csr_access;
	csr_io_pkg::trap_req_t trap_req;
	logic m_ext;
	logic s_ext;
	logic [31:0] rdata;
	csr_io_pkg::redirect_t redirect;

	stim_t stim_q[$];
	logic stim_ready;

	csr_trap_unit
	#(
		.COUNT_WIDTH (COUNT_WIDTH)
	)
	csr_trap_unit_inst
	(
		.clk        (clk),
		.nrst       (nrst),
		.csr_access (csr_access),
		.trap_req   (trap_req),
		.m_ext      (m_ext),
		.s_ext      (s_ext),
		.rdata      (rdata),
		.redirect   (redirect)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic drive_idle();
		csr_access = '0;
		trap_req = '0;
	endtask

	task automatic load_stim();
		int fd;
		logic [7:0] op;
		logic [31:0] addr, data, pc, cause, exp_val;
		logic [8*200-1:0] skip_buf;
		stim_t s;
		fd = $fopen("csr_stim.txt", "r");
		if (fd == 0)
			fail_run("could not open csr_stim.txt");
		while ($fscanf(fd, " %c", op) == 1)
		begin
			if (op == "#")
				void'($fgets(skip_buf, fd));	// rest of a comment line
			else
			begin
				void'($fscanf(fd, "%h %h %h %h %h", addr, data, pc, cause, exp_val));
				s.op = op;
				s.addr = addr[11:0];
				s.data = data;
				s.pc = pc;
				s.cause = cause;
				s.exp_val = exp_val;
				s.idx = 16'(stim_q.size() + 1);
				stim_q.push_back(s);
			end
		end
		$fclose(fd);
	endtask

	task automatic check_no_redirect(input stim_t s);
		assert (redirect.valid == 1'b0)
		else fail_run($sformatf("[ERROR] redirect.valid: got %h expected 0 (op %0d)",
			redirect.valid, s.idx));
	endtask

	task automatic check_redirect(input stim_t s);
		assert (redirect.valid == 1'b1)
		else fail_run($sformatf("[ERROR] redirect.valid: got %h expected 1 (op %0d)",
			redirect.valid, s.idx));
		assert (redirect.pc == s.exp_val)
		else fail_run($sformatf("[ERROR] redirect.pc: got %08h expected %08h (op %0d)",
			redirect.pc, s.exp_val, s.idx));
	endtask

	task automatic run_write(input stim_t s);
		@(negedge clk);
		drive_idle();
		csr_access.valid = 1'b1;
		csr_access.write = 1'b1;
		csr_access.addr = s.addr;
		csr_access.wdata = s.data;
		#1;
		check_no_redirect(s);
	endtask

	task automatic run_read(input stim_t s);
		@(negedge clk);
		drive_idle();
		csr_access.valid = 1'b1;
		csr_access.addr = s.addr;
		#1;	// rdata is combinational, settled well before the rising edge
		assert (rdata == s.exp_val)
		else fail_run($sformatf("[ERROR] rdata at csr %03h: got %08h expected %08h (op %0d)",
			s.addr, rdata, s.exp_val, s.idx));
		check_no_redirect(s);
	endtask

	task automatic run_trap(input stim_t s);
		@(negedge clk);
		drive_idle();
		trap_req.valid = 1'b1;
		trap_req.cause.irq = s.cause[31];
		trap_req.cause.code = s.cause[30:0];
		trap_req.pc = s.pc;
		#1;
		check_redirect(s);
	endtask

	task automatic run_return(input stim_t s, input logic is_mret);
		@(negedge clk);
		drive_idle();
		trap_req.valid = 1'b1;
		trap_req.mret = is_mret;
		trap_req.sret = !is_mret;
		#1;
		check_redirect(s);
	endtask

	// idle cycles; an interrupt may be taken on one of them
	task automatic run_wait(input stim_t s);
		int fires;
		fires = 0;
		repeat (s.data)
		begin
			@(negedge clk);
			drive_idle();
			trap_req.pc = s.pc;	// pc recorded if an interrupt lands here
			#1;
			if (redirect.valid)
			begin
				fires++;
				check_redirect(s);
			end
		end
		if (s.exp_val == 32'b0)
		begin
			assert (fires == 0)
			else fail_run($sformatf("an interrupt was taken during a quiet wait (op %0d)",
				s.idx));
		end
		else
		begin
			assert (fires == 1)
			else fail_run($sformatf("expected one interrupt during the wait, saw %0d (op %0d)",
				fires, s.idx));
		end
	endtask

	initial
	begin
		wait (stim_ready);
		repeat (stim_q.size() * CYCLES_PER_OP) @(posedge clk);
		fail_run("watchdog expired before the stim file was finished");
	end

	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		m_ext = 1'b0;
		s_ext = 1'b0;
		drive_idle();
		stim_ready = 1'b0;
		load_stim();
		if (stim_q.size() == 0)
			fail_run("no operations found in csr_stim.txt");
		stim_ready = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		foreach (stim_q[i])
		begin
			case (stim_q[i].op)
				"W": run_write(stim_q[i]);
				"R": run_read(stim_q[i]);
				"T": run_trap(stim_q[i]);
				"M": run_return(stim_q[i], 1'b1);
				"S": run_return(stim_q[i], 1'b0);
				"I": run_wait(stim_q[i]);
				default: fail_run($sformatf("unknown operation in stim file (op %0d)",
					stim_q[i].idx));
			endcase
		end
		@(negedge clk);
		drive_idle();
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== trap_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_controller
(
	input  csr_io_pkg::trap_req_t trap,
	input  csr_io_pkg::trap_state_t state,
	input  logic m_timer,
	input  logic s_timer,
	input  logic m_ext,
	input  logic s_ext,
	input  logic [31:0] reg_rdata,
	input  logic reg_hit,
	input  logic [31:0] tmr_rdata,
	input  logic tmr_hit,
	input  logic [31:0] mtvec,
	input  logic [31:0] stvec,
	input  logic [31:0] mepc,
	input  logic [31:0] sepc,
	output logic [31:0] rdata,
	output logic take_trap,
	output csr_arch_pkg::mode_t target_mode,
	output csr_io_pkg::trap_req_t cause_out,
	output csr_io_pkg::redirect_t redirect
);

	logic m_level_en, s_level_en;
	logic [3:0] irq_ok;	// m_ext, m_timer, s_ext, s_timer
	logic irq_take;
	logic [30:0] irq_code;
	logic exc, ret, deleg;

	assign rdata = reg_hit ? reg_rdata : (tmr_hit ? tmr_rdata : 32'b0);

	// M level is masked only in M with mie clear, S level never fires in M
	assign m_level_en = (state.mode != csr_arch_pkg::MODE_M) || state.mie;
	assign s_level_en = (state.mode == csr_arch_pkg::MODE_U) ||
		(state.mode == csr_arch_pkg::MODE_S && state.sie);

	always_comb
	begin
		irq_ok[3] = m_ext && state.meie && (state.mideleg[11] ? s_level_en : m_level_en);
		irq_ok[2] = m_timer && state.mtie && (state.mideleg[7] ? s_level_en : m_level_en);
		irq_ok[1] = s_ext && state.seie && (state.mideleg[9] ? s_level_en : m_level_en);
		irq_ok[0] = s_timer && state.stie && (state.mideleg[5] ? s_level_en : m_level_en);
		irq_take = |irq_ok;
		if (irq_ok[3])
			irq_code = csr_arch_pkg::IRQ_M_EXT;
		else if (irq_ok[2])
			irq_code = csr_arch_pkg::IRQ_M_TIMER;
		else if (irq_ok[1])
			irq_code = csr_arch_pkg::IRQ_S_EXT;
		else if (irq_ok[0])
			irq_code = csr_arch_pkg::IRQ_S_TIMER;
		else
			irq_code = '0;
	end

	always_comb
	begin
		exc = trap.valid && !trap.mret && !trap.sret;
		ret = trap.valid && (trap.mret || trap.sret);
		take_trap = exc || (!trap.valid && irq_take);	// requests win over interrupts

		cause_out = trap;
		if (!trap.valid && irq_take)
		begin
			cause_out.valid = 1'b1;
			cause_out.cause.irq = 1'b1;
			cause_out.cause.code = irq_code;
		end

		if (cause_out.cause.irq)
			deleg = (cause_out.cause.code < 31'd12) && state.mideleg[cause_out.cause.code[3:0]];
		else
			deleg = (cause_out.cause.code < 31'd16) && state.medeleg[cause_out.cause.code[3:0]];

		if (ret)
			target_mode = trap.mret ? state.mpp
				: (state.spp ? csr_arch_pkg::MODE_S : csr_arch_pkg::MODE_U);
		else if (take_trap && state.mode != csr_arch_pkg::MODE_M && deleg)
			target_mode = csr_arch_pkg::MODE_S;
		else if (take_trap)
			target_mode = csr_arch_pkg::MODE_M;
		else
			target_mode = state.mode;

		redirect.valid = take_trap || ret;
		if (ret)
			redirect.pc = trap.mret ? mepc : sepc;
		else if (take_trap)
			redirect.pc = (target_mode == csr_arch_pkg::MODE_S) ? stvec : mtvec;
		else
			redirect.pc = 32'b0;
	end

	always_comb
	begin
		a_one_return: assert final (!(trap.valid && trap.mret && trap.sret))
			else $error("mret and sret on the same request");
		a_one_owner: assert final (!(reg_hit && tmr_hit))
			else $error("csr address claimed by regfile and timer");
	end

endmodule

`default_nettype wire
